//--- hdl/mapper_settings.svh
// Map viewer constants
`ifndef MAPPER_SETTINGS_SVH
`define MAPPER_SETTINGS_SVH

// ----------------------------------------------------------
// bus widths
`define MAP_COORD_W       10
`define MAP_SCROLL_W      11
`define MAP_ADDR_W        19

// ----------------------------------------------------------
// game window on the 640x480 screen
`define MAP_WIN_X0        80
`define MAP_WIN_Y0        80
`define MAP_WIN_W         480
`define MAP_WIN_H         320

// map image is 480 words per row, as many rows as window lines
`define MAP_ROW_W         480

// scroll limits, top left corner of the view in map pixels
`define MAP_SCROLL_X_MIN  (-30)
`define MAP_SCROLL_Y_MIN  (-30)
`define MAP_SCROLL_X_MAX  269
`define MAP_SCROLL_Y_MAX  189

// ----------------------------------------------------------
// player sprite, fixed at screen centre
`define MAP_SPR_X         320
`define MAP_SPR_Y         240
`define MAP_SPR_HALF_W    6
`define MAP_SPR_HALF_H    10
`define MAP_SPR_RGB       24'hff5500

// usb keyboard codes
`define MAP_KEY_A         8'h04
`define MAP_KEY_D         8'h07
`define MAP_KEY_W         8'h1A
`define MAP_KEY_S         8'h16

`endif

//--- hdl/mapperPkg.sv
// Map viewer shared types
`include "mapper_settings.svh"

package mapperPkg;

    // ----------------------------------------------------------
    // motion from the keyboard

    // one step per frame on a single axis
    typedef enum logic [1:0] {
        STEP_NEG,
        STEP_NONE,
        STEP_POS
    } axisStepT;

    typedef struct packed {
        axisStepT stepX;
        axisStepT stepY;
    } motionT;

    // view corner in map pixels, can go slightly negative
    typedef struct packed {
        logic signed [`MAP_SCROLL_W-1:0] x;
        logic signed [`MAP_SCROLL_W-1:0] y;
    } scrollPosT;

    // ----------------------------------------------------------
    // pixel stream

    // screen coordinate from the vga timing generator
    typedef struct packed {
        logic [`MAP_COORD_W-1:0] drawX;
        logic [`MAP_COORD_W-1:0] drawY;
    } pixelCoordT;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgbT;

    // what a pixel shows, decided in stage 1
    typedef enum logic [1:0] {
        PIX_BLANK,
        PIX_SPRITE,
        PIX_MAP,
        PIX_OUTSIDE
    } pixelClassT;

endpackage

//--- hdl/keyDecode.sv
// Keyboard motion decoder
`timescale 1ns/10ps
`include "mapper_settings.svh"

module keyDecode (
    input  logic [15:0]       keycode,
    output mapperPkg::motionT motion
);

    // two key slots from the keyboard report
    logic [7:0] keyLow;
    logic [7:0] keyHigh;

    // key held in either slot
    logic hasA;
    logic hasD;
    logic hasW;
    logic hasS;

    // ----------------------------------------------------------
    // opposing keys cancel on an axis
    function automatic mapperPkg::axisStepT axisRule(
        input logic negKey,
        input logic posKey
    );
        if (negKey && !posKey) begin
            return mapperPkg::STEP_NEG;
        end else if (posKey && !negKey) begin
            return mapperPkg::STEP_POS;
        end
        // no key, or both at once
        return mapperPkg::STEP_NONE;
    endfunction

    assign keyLow  = keycode[7:0];
    assign keyHigh = keycode[15:8];

    // byte order does not matter
    assign hasA = (keyLow == `MAP_KEY_A) || (keyHigh == `MAP_KEY_A);
    assign hasD = (keyLow == `MAP_KEY_D) || (keyHigh == `MAP_KEY_D);
    assign hasW = (keyLow == `MAP_KEY_W) || (keyHigh == `MAP_KEY_W);
    assign hasS = (keyLow == `MAP_KEY_S) || (keyHigh == `MAP_KEY_S);

    // left/right on x, up/down on y
    always_comb begin
        motion.stepX = axisRule(hasA, hasD);
        motion.stepY = axisRule(hasW, hasS);
    end

endmodule

//--- hdl/scrollExecute.sv
// Scroll position register
`timescale 1ns/10ps
`include "mapper_settings.svh"

module scrollExecute (
    input  logic                 frame_clk,
    input  logic                 Reset,
    input  logic                 frameStart,
    input  mapperPkg::motionT    motion,
    output mapperPkg::scrollPosT scrollPos
);

    // candidate position for the next frame
    mapperPkg::scrollPosT scrollNext;

    // ----------------------------------------------------------
    // one axis: add the step, then saturate at the map limits
    function automatic logic signed [`MAP_SCROLL_W-1:0] stepAxis(
        input logic signed [`MAP_SCROLL_W-1:0] pos,
        input mapperPkg::axisStepT             step,
        input int                              lo,
        input int                              hi
    );
        int sum;
        case (step)
            mapperPkg::STEP_NEG: sum = int'(pos) - 1;
            mapperPkg::STEP_POS: sum = int'(pos) + 1;
            default:             sum = int'(pos);
        endcase
        // clamp, the view never leaves the map border
        if (sum < lo) begin
            sum = lo;
        end else if (sum > hi) begin
            sum = hi;
        end
        return `MAP_SCROLL_W'(sum);
    endfunction

    always_comb begin
        scrollNext.x = stepAxis(scrollPos.x, motion.stepX,
                                `MAP_SCROLL_X_MIN, `MAP_SCROLL_X_MAX);
        scrollNext.y = stepAxis(scrollPos.y, motion.stepY,
                                `MAP_SCROLL_Y_MIN, `MAP_SCROLL_Y_MAX);
    end

    // update once per frame, hold otherwise
    always_ff @(posedge frame_clk or posedge Reset) begin
        if (Reset) begin
            scrollPos <= '0;
        end else if (frameStart) begin
            scrollPos <= scrollNext;
        end
    end

    // ----------------------------------------------------------
    // position stays inside the limits across all frames
    scrollInLimits: assert property (@(posedge frame_clk) disable iff (Reset)
        (scrollPos.x >= `MAP_SCROLL_X_MIN) && (scrollPos.x <= `MAP_SCROLL_X_MAX) &&
        (scrollPos.y >= `MAP_SCROLL_Y_MIN) && (scrollPos.y <= `MAP_SCROLL_Y_MAX))
        else $error("scrollExecute: position (%0d,%0d) out of limits",
                    scrollPos.x, scrollPos.y);

endmodule

//--- hdl/pixelResult.sv
// Pixel colour pipeline
`timescale 1ns/10ps
`include "mapper_settings.svh"

module pixelResult (
    input  logic                   frame_clk,
    input  logic                   Reset,
    input  logic                   videoOn,
    input  mapperPkg::pixelCoordT  pixel,
    input  mapperPkg::scrollPosT   scrollPos,
    output logic [`MAP_ADDR_W-1:0] mapAddr,
    input  logic [3:0]             mapIndex,
    output mapperPkg::rgbT         rgb
);

    // offset from sprite centre
    int spriteDx;
    int spriteDy;
    logic onSprite;
    logic inWindow;

    // map coordinate at full resolution, signed
    int mapX;
    int mapY;
    logic onMap;

    mapperPkg::pixelClassT  classNext;
    logic [`MAP_ADDR_W-1:0] mapAddrNext;

    // class travels alongside the memory read
    mapperPkg::pixelClassT classS1;
    mapperPkg::pixelClassT classS2;
    mapperPkg::rgbT        rgbNext;

    // ----------------------------------------------------------
    // fixed 16 entry palette, 4 bit channels in the high nibble
    function automatic mapperPkg::rgbT paletteLookup(input logic [3:0] index);
        mapperPkg::rgbT entry;
        entry.red   = {index, 4'h0};
        entry.green = {4'hf - index, 4'h0};
        entry.blue  = {index ^ 4'h5, 4'h0};
        return entry;
    endfunction

    // ----------------------------------------------------------
    // stage 1: classify and address
    always_comb begin
        spriteDx = int'(pixel.drawX) - `MAP_SPR_X;
        spriteDy = int'(pixel.drawY) - `MAP_SPR_Y;
        onSprite = (spriteDx >= -`MAP_SPR_HALF_W) && (spriteDx <= `MAP_SPR_HALF_W) &&
                   (spriteDy >= -`MAP_SPR_HALF_H) && (spriteDy <= `MAP_SPR_HALF_H);

        inWindow = (pixel.drawX >= `MAP_WIN_X0) &&
                   (pixel.drawX < `MAP_WIN_X0 + `MAP_WIN_W) &&
                   (pixel.drawY >= `MAP_WIN_Y0) &&
                   (pixel.drawY < `MAP_WIN_Y0 + `MAP_WIN_H);

        // window pixel plus twice the scroll, map drawn at half resolution
        mapX = int'(pixel.drawX) - `MAP_WIN_X0 + 2 * int'(scrollPos.x);
        mapY = int'(pixel.drawY) - `MAP_WIN_Y0 + 2 * int'(scrollPos.y);
        onMap = inWindow && (mapX >= 0) && (mapX < 2 * `MAP_ROW_W) &&
                (mapY >= 0) && (mapY < 2 * `MAP_WIN_H);

        // halve both coordinates, row major word address
        mapAddrNext = `MAP_ADDR_W'((mapX >>> 1) + (mapY >>> 1) * `MAP_ROW_W);

        // sprite drawn over the map
        if (!videoOn) begin
            classNext = mapperPkg::PIX_BLANK;
        end else if (onSprite) begin
            classNext = mapperPkg::PIX_SPRITE;
        end else if (onMap) begin
            classNext = mapperPkg::PIX_MAP;
        end else begin
            classNext = mapperPkg::PIX_OUTSIDE;
        end
    end

    // address out to the map memory, one cycle after the pixel
    always_ff @(posedge frame_clk or posedge Reset) begin
        if (Reset) begin
            classS1 <= mapperPkg::PIX_BLANK;
            mapAddr <= '0;
        end else begin
            classS1 <= classNext;
            mapAddr <= mapAddrNext;
        end
    end

    // wait one cycle while the memory registers mapIndex
    always_ff @(posedge frame_clk or posedge Reset) begin
        if (Reset) begin
            classS2 <= mapperPkg::PIX_BLANK;
        end else begin
            classS2 <= classS1;
        end
    end

    // ----------------------------------------------------------
    // stage 2: colour select
    always_comb begin
        case (classS2)
            mapperPkg::PIX_SPRITE: rgbNext = `MAP_SPR_RGB;
            mapperPkg::PIX_MAP:    rgbNext = paletteLookup(mapIndex);
            default:               rgbNext = '0;
        endcase
    end

    // blank and outside both black
    always_ff @(posedge frame_clk or posedge Reset) begin
        if (Reset) begin
            rgb <= '0;
        end else begin
            rgb <= rgbNext;
        end
    end

    // map pixels only ever address inside the image
    mapAddrInImage: assert property (@(posedge frame_clk) disable iff (Reset)
        (classS1 == mapperPkg::PIX_MAP) |-> (mapAddr < `MAP_ROW_W * `MAP_WIN_H))
        else $error("pixelResult: map address %0d beyond image", mapAddr);

endmodule

//--- hdl/colorMapper.sv
// Scrolling map viewer top
`timescale 1ns/10ps
`include "mapper_settings.svh"

module colorMapper (
    input  logic                    frame_clk,
    input  logic                    Reset,
    input  logic                    frameStart,
    input  logic                    videoOn,
    input  logic [15:0]             keycode,
    input  logic [`MAP_COORD_W-1:0] drawX,
    input  logic [`MAP_COORD_W-1:0] drawY,
    input  logic [3:0]              mapIndex,
    output logic [`MAP_ADDR_W-1:0]  mapAddr,
    output mapperPkg::rgbT          rgb,
    output mapperPkg::scrollPosT    scrollPos
);

    // decoded key motion
    mapperPkg::motionT     motion;
    // screen coordinate bundle
    mapperPkg::pixelCoordT pixel;

    assign pixel.drawX = drawX;
    assign pixel.drawY = drawY;

    // ----------------------------------------------------------
    // keycode to per-axis step
    keyDecode i_keyDecode (
        .keycode (keycode),
        .motion  (motion)
    );

    // view position, once per frame
    scrollExecute i_scrollExecute (
        .frame_clk  (frame_clk),
        .Reset      (Reset),
        .frameStart (frameStart),
        .motion     (motion),
        .scrollPos  (scrollPos)
    );

    // pixel pipeline, map memory sits outside
    pixelResult i_pixelResult (
        .frame_clk (frame_clk),
        .Reset     (Reset),
        .videoOn   (videoOn),
        .pixel     (pixel),
        .scrollPos (scrollPos),
        .mapAddr   (mapAddr),
        .mapIndex  (mapIndex),
        .rgb       (rgb)
    );

endmodule

//--- test/colorMapperTb.sv
// Map viewer testbench
`timescale 1ns/10ps
`include "mapper_settings.svh"

module colorMapperTb;

    // pipeline depth seen from the pixel inputs
    localparam int addrLatency = 1;
    localparam int rgbLatency  = 3;
    localparam int drainLimit  = 16;

    logic                    frame_clk;
    logic                    Reset;
    logic                    frameStart;
    logic                    videoOn;
    logic [15:0]             keycode;
    logic [`MAP_COORD_W-1:0] drawX;
    logic [`MAP_COORD_W-1:0] drawY;
    logic [3:0]              mapIndex;
    logic [`MAP_ADDR_W-1:0]  mapAddr;
    mapperPkg::rgbT          rgb;
    mapperPkg::scrollPosT    scrollPos;

    int cycleCount;

    // pixels in flight with the oldest at the front
    string addrNameQ[$];
    int    addrIssueQ[$];
    int    addrExpQ[$];
    string rgbNameQ[$];
    int    rgbIssueQ[$];
    int    rgbExpQ[$];

    colorMapper i_colorMapper (
        .frame_clk  (frame_clk),
        .Reset      (Reset),
        .frameStart (frameStart),
        .videoOn    (videoOn),
        .keycode    (keycode),
        .drawX      (drawX),
        .drawY      (drawY),
        .mapIndex   (mapIndex),
        .mapAddr    (mapAddr),
        .rgb        (rgb),
        .scrollPos  (scrollPos)
    );

    // ----------------------------------------------------------
    // 8 ns pixel clock
    initial begin
        frame_clk = 1'b0;
        forever #4 frame_clk = ~frame_clk;
    end

    // synchronous map rom returning the low nibble of the address
    always @(posedge frame_clk) begin
        mapIndex   <= mapAddr[3:0];
        cycleCount <= cycleCount + 1;
    end

    task automatic checkValue(input string testName, input string what,
                              input logic signed [31:0] expected,
                              input logic signed [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %0d (0x%h), actual %0d (0x%h)",
                     testName, what, expected, expected, actual, actual);
            $display("*** FAILED ***");
            $fatal(1, "%s: %s mismatch", testName, what);
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic nextCycle();
        @(posedge frame_clk);
        #1;
    endtask

    // ----------------------------------------------------------
    // outputs sampled mid cycle away from both edges
    always @(negedge frame_clk) begin
        if (addrIssueQ.size() > 0 && cycleCount == addrIssueQ[0] + addrLatency) begin
            checkValue(addrNameQ[0], "mapAddr", addrExpQ[0], mapAddr);
            void'(addrNameQ.pop_front());
            void'(addrIssueQ.pop_front());
            void'(addrExpQ.pop_front());
        end
        if (rgbIssueQ.size() > 0 && cycleCount == rgbIssueQ[0] + rgbLatency) begin
            checkValue(rgbNameQ[0], "rgb", rgbExpQ[0], rgb);
            void'(rgbNameQ.pop_front());
            void'(rgbIssueQ.pop_front());
            void'(rgbExpQ.pop_front());
        end
    end

    // idle the pixel input until every pending result is checked
    task automatic drainPipeline();
        int waitCount;
        waitCount = 0;
        videoOn = 1'b0;
        while ((addrIssueQ.size() > 0 || rgbIssueQ.size() > 0) && waitCount < drainLimit) begin
            nextCycle();
            waitCount++;
        end
        if (addrIssueQ.size() > 0 || rgbIssueQ.size() > 0) begin
            $display("timeout: pixel results still pending after %0d cycles", waitCount);
            $display("*** FAILED ***");
            $fatal(1, "pipeline drain timeout");
        end
    endtask

    // key held over some frame pulses and then a few idle cycles
    task automatic runKeyCase(input string testName, input logic [15:0] key,
                              input int frames, input int expX, input int expY);
        drainPipeline();
        keycode = key;
        for (int i = 0; i < frames; i++) begin
            frameStart = 1'b1;
            nextCycle();
        end
        frameStart = 1'b0;
        // position must hold while the key stays down
        repeat (4) nextCycle();
        keycode = 16'h0000;
        checkValue(testName, "scrollPos.x", expX, $signed(scrollPos.x));
        checkValue(testName, "scrollPos.y", expY, $signed(scrollPos.y));
    endtask

    // one pixel per call so back to back calls fill the pipeline
    task automatic issuePixel(input string testName, input int pixX, input int pixY,
                              input int pixOn, input int expRgb, input int expAddr);
        drawX   = pixX[`MAP_COORD_W-1:0];
        drawY   = pixY[`MAP_COORD_W-1:0];
        videoOn = pixOn[0];
        rgbNameQ.push_back(testName);
        rgbIssueQ.push_back(cycleCount);
        rgbExpQ.push_back(expRgb);
        // negative address means no map access to check
        if (expAddr >= 0) begin
            addrNameQ.push_back(testName);
            addrIssueQ.push_back(cycleCount);
            addrExpQ.push_back(expAddr);
        end
        nextCycle();
    endtask

    // ----------------------------------------------------------
    // case file reader
    task automatic runCaseFile();
        int    fd;
        int    code;
        int    caseCount;
        string testName;
        string kind;
        string skipLine;
        int    key;
        int    frames;
        int    pixX;
        int    pixY;
        int    pixOn;
        int    expA;
        int    expB;
        caseCount = 0;
        fd = $fopen("test/mapperCases.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/mapperCases.txt");
            $display("*** FAILED ***");
            $fatal(1, "case file missing");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", testName);
            if (code != 1) begin
                break;
            end
            if (testName.getc(0) == 8'h23) begin
                // comment line
                code = $fgets(skipLine, fd);
            end else begin
                code = $fscanf(fd, " %s %h %d %d %d %d", kind, key, frames, pixX, pixY, pixOn);
                if (kind == "KEY") begin
                    code += $fscanf(fd, " %d %d", expA, expB);
                end else begin
                    code += $fscanf(fd, " %h %h", expA, expB);
                end
                if (code != 8 || (kind != "KEY" && kind != "PIX")) begin
                    $display("malformed case line for test %s", testName);
                    $display("*** FAILED ***");
                    $fatal(1, "bad case file");
                end
                if (kind == "KEY") begin
                    runKeyCase(testName, key[15:0], frames, expA, expB);
                end else begin
                    issuePixel(testName, pixX, pixY, pixOn, expA, expB);
                end
                caseCount++;
            end
        end
        $fclose(fd);
        drainPipeline();
        if (caseCount == 0) begin
            $display("no cases found in test/mapperCases.txt");
            $display("*** FAILED ***");
            $fatal(1, "empty case file");
        end
    endtask

    // ----------------------------------------------------------
    // main sequence
    initial begin
        Reset      = 1'b1;
        frameStart = 1'b0;
        videoOn    = 1'b0;
        keycode    = 16'h0000;
        drawX      = '0;
        drawY      = '0;
        mapIndex   = 4'h0;
        cycleCount = 0;

        repeat (8) @(posedge frame_clk);
        #1;
        Reset = 1'b0;
        checkValue("reset", "rgb", 0, rgb);

        runCaseFile();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- test/mapperCases.txt
# name kind keycode frames drawX drawY videoOn expected
# KEY: scroll x y in decimal; PIX: rgb, mapAddr in hex, ffffffff skips mapAddr
resetPos KEY 0000 0 0 0 0 0 0
keyD5 KEY 0007 5 0 0 0 5 0
holdD KEY 0007 0 0 0 0 5 0
keyW3 KEY 001A 3 0 0 0 5 -3
keyS4 KEY 1600 4 0 0 0 5 1
diagAW KEY 1A04 2 0 0 0 3 -1
diagWA KEY 041A 2 0 0 0 1 -3
diagDS KEY 0716 4 0 0 0 5 1
diagSD KEY 1607 3 0 0 0 8 4
keyAD KEY 0704 6 0 0 0 8 4
clampA KEY 0004 40 0 0 0 -30 4
clampS KEY 0016 200 0 0 0 -30 189
offMapLeft PIX 0000 0 100 200 1 000000 ffffffff
edgeMap PIX 0000 0 300 200 1 00f050 1d330
offMapBottom PIX 0000 0 300 350 1 000000 ffffffff
backD KEY 0007 40 0 0 0 10 189
backW KEY 001A 150 0 0 0 10 39
winA PIX 0000 0 100 100 1 40b010 5bf4
winB PIX 0000 0 101 100 1 40b010 5bf4
winC PIX 0000 0 200 150 1 609030 8b06
winD PIX 0000 0 455 333 1 50a000 13625
sprCentre PIX 0000 0 320 240 1 ff5500 ffffffff
sprEdge PIX 0000 0 326 250 1 ff5500 ffffffff
besideSpr PIX 0000 0 327 240 1 50a000 dfa5
winCorner PIX 0000 0 80 80 1 a050f0 492a
outsideWin PIX 0000 0 40 240 1 000000 ffffffff
blankPix PIX 0000 0 200 150 0 000000 ffffffff

//--- src.f
+incdir+hdl
hdl/mapperPkg.sv
hdl/keyDecode.sv
hdl/scrollExecute.sv
hdl/pixelResult.sv
hdl/colorMapper.sv
test/colorMapperTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the map viewer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f src.f --top-module colorMapperTb -o colorMapperSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/colorMapperSim)
simStatus=$?
echo "$simOutput"

if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
